/* logic/periph_params.svh */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

`define PERIPH_ADDR_W		11		// Word address into data memory

// Input mailbox, written by the CPU
`define MB_SPI_DIN		11'h001
`define MB_SPI_CON		11'h002
`define MB_UART_DIN		11'h003
`define MB_UART_CON		11'h004

// Output mailbox, written by the poller
`define MB_SPI_STAT		11'h401
`define MB_SPI_DOUT		11'h402
`define MB_UART_STAT	11'h403
`define MB_UART_DOUT	11'h404

`define PERIPH_SWEEP_LEN	16		// Cycles per poll sweep
`define PERIPH_FRAME_W		8		// SPI and UART data bits

`endif

/* logic/periph_pkg.sv */
`include "periph_params.svh"

package periph_pkg;

	// One memory access per cycle, wstrb zero means read
	typedef struct packed {
		logic [`PERIPH_ADDR_W-1:0]	addr;
		logic [31:0]				wdata;
		logic [3:0]					wstrb;
	} mem_req_t;

	typedef struct packed {
		logic [23:0]	prescale;	// SCK half period minus one
		logic [1:0]		rsvd;
		logic [1:0]		select;		// Chip select number
		logic			order;		// Set sends LSB first
		logic			cpha;
		logic			cpol;
		logic			enable;		// Start or hold a transfer
	} spi_con_t;

	typedef struct packed {
		logic [23:0]	baud_div;	// Clocks per bit minus one
		logic [5:0]		rsvd;
		logic			parity_en;	// Even parity bit after data
		logic			tx_go;		// Request transmission
	} uart_con_t;

	typedef struct packed {
		logic [29:0]	rsvd;
		logic			done;
		logic			busy;
	} spi_stat_t;

	typedef struct packed {
		logic [24:0]	rsvd;
		logic [3:0]		rx_count;		// Wraps after 15
		logic			rx_parity_err;
		logic			tx_done;
		logic			tx_busy;
	} uart_stat_t;

endpackage

/* logic/mailbox_poller.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module mailbox_poller (
	input  logic						clk,
	input  logic						nrst,

	input  logic [31:0]					mem_rdata_i,	// Valid one cycle after a read
	output periph_pkg::mem_req_t		mem_req_o,

	output periph_pkg::spi_con_t		spi_con_o,
	output logic [`PERIPH_FRAME_W-1:0]	spi_din_o,
	input  periph_pkg::spi_stat_t		spi_stat_i,
	input  logic [`PERIPH_FRAME_W-1:0]	spi_dout_i,

	output periph_pkg::uart_con_t		uart_con_o,
	output logic [`PERIPH_FRAME_W-1:0]	uart_din_o,
	input  periph_pkg::uart_stat_t		uart_stat_i,
	input  logic [`PERIPH_FRAME_W-1:0]	uart_dout_i,

	output logic						irq_o
);

	localparam int SLOT_W = $clog2(`PERIPH_SWEEP_LEN);
	localparam int PAD_W = 32 - `PERIPH_FRAME_W;

	logic [SLOT_W-1:0]	slot;		// Position in the sweep
	logic [3:0]			last_rx_count;	// Count seen at the previous status write
	logic				rx_pend;		// Receive event within the last sweep

	// Schedule and control latches
	always_ff @(posedge clk) begin
		if (!nrst) begin
			slot			<= '0;
			mem_req_o		<= '0;
			spi_con_o		<= '0;
			uart_con_o		<= '0;
			last_rx_count	<= '0;
			rx_pend			<= 1'b0;
			irq_o			<= 1'b0;
		end else begin
			slot <= (slot == SLOT_W'(`PERIPH_SWEEP_LEN - 1)) ? '0 : slot + 1'b1;
			mem_req_o.wstrb	<= 4'h0;	// Odd slots stay idle
			mem_req_o.wdata	<= '0;
			case (slot)
				SLOT_W'(0): mem_req_o.addr <= `MB_SPI_DIN;
				SLOT_W'(2): mem_req_o.addr <= `MB_SPI_CON;	// SPI data lands now
				SLOT_W'(4): begin
					mem_req_o.addr	<= `MB_SPI_STAT;
					mem_req_o.wdata	<= spi_stat_i;
					mem_req_o.wstrb	<= 4'hf;
					spi_con_o		<= mem_rdata_i;	// Control read from slot 2
				end
				SLOT_W'(6): begin
					mem_req_o.addr	<= `MB_SPI_DOUT;
					mem_req_o.wdata	<= {{PAD_W{1'b0}}, spi_dout_i};
					mem_req_o.wstrb	<= 4'hf;
				end
				SLOT_W'(8): mem_req_o.addr <= `MB_UART_DIN;
				SLOT_W'(10): mem_req_o.addr <= `MB_UART_CON;
				SLOT_W'(12): begin
					mem_req_o.addr	<= `MB_UART_STAT;
					mem_req_o.wdata	<= uart_stat_i;
					mem_req_o.wstrb	<= 4'hf;
					uart_con_o		<= mem_rdata_i;
					// A count change arms the receive interrupt for one sweep
					rx_pend			<= (uart_stat_i.rx_count != last_rx_count);
					last_rx_count	<= uart_stat_i.rx_count;
				end
				SLOT_W'(14): begin
					mem_req_o.addr	<= `MB_UART_DOUT;
					mem_req_o.wdata	<= {{PAD_W{1'b0}}, uart_dout_i};
					mem_req_o.wstrb	<= 4'hf;
				end
				default: ;	// Address held, read result ignored
			endcase
			irq_o <= spi_stat_i.done | uart_stat_i.tx_done | rx_pend;
		end
	end

	// Data bytes, two cycles after their read request
	always_ff @(posedge clk) begin
		if (slot == SLOT_W'(2))
			spi_din_o <= mem_rdata_i[`PERIPH_FRAME_W-1:0];
		if (slot == SLOT_W'(10))
			uart_din_o <= mem_rdata_i[`PERIPH_FRAME_W-1:0];
	end

endmodule

/* logic/spi_master.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module spi_master (
	input  logic						clk,
	input  logic						nrst,
	input  periph_pkg::spi_con_t		con_i,
	input  logic [`PERIPH_FRAME_W-1:0]	din_i,
	output periph_pkg::spi_stat_t		stat_o,
	output logic [`PERIPH_FRAME_W-1:0]	dout_o,
	output logic						sck_o,
	output logic						mosi_o,
	input  logic						miso_i,
	output logic [3:0]					ss_n_o
);

	localparam int W = `PERIPH_FRAME_W;
	localparam int EDGE_W = $clog2(2 * W);

	periph_pkg::spi_con_t	cfg_q;		// Mode captured at frame start
	logic					busy;
	logic					done;
	logic					sclk;
	logic [23:0]			presc_cnt;
	logic [EDGE_W-1:0]		edge_cnt;	// SCK edges already made
	logic [W-1:0]			tx_sh;		// MSB goes out first
	logic [W-1:0]			rx_sh;
	logic [W-1:0]			rx_next;
	logic [W-1:0]			rx_word;
	logic [W-1:0]			rx_rev;
	logic [W-1:0]			din_rev;
	logic					start;
	logic					tick;
	logic					sample;
	logic					last_edge;

	assign start = con_i.enable & ~busy & ~done;
	assign tick = busy & (presc_cnt == cfg_q.prescale);	// Half period elapsed
	// Even count is a leading edge; cpha moves sampling to trailing edges
	assign sample = ~edge_cnt[0] ^ cfg_q.cpha;
	assign last_edge = (edge_cnt == EDGE_W'(2 * W - 1));
	assign rx_next = {rx_sh[W-2:0], miso_i};
	assign rx_word = sample ? rx_next : rx_sh;	// cpha=1 samples on the last edge
	assign rx_rev = {<<{rx_word}};
	assign din_rev = {<<{din_i}};

	always_ff @(posedge clk) begin
		if (!nrst) begin
			busy		<= 1'b0;
			done		<= 1'b0;
			sclk		<= 1'b0;
			presc_cnt	<= '0;
			edge_cnt	<= '0;
			dout_o		<= '0;
		end else begin
			if (start) begin
				busy		<= 1'b1;
				presc_cnt	<= '0;
				edge_cnt	<= '0;
				sclk		<= con_i.cpol;
			end else if (busy) begin
				if (tick) begin
					presc_cnt	<= '0;
					sclk		<= ~sclk;
					edge_cnt	<= edge_cnt + 1'b1;
					if (last_edge) begin	// 16th edge ends the frame
						busy	<= 1'b0;
						done	<= 1'b1;
						dout_o	<= cfg_q.order ? rx_rev : rx_word;
					end
				end else begin
					presc_cnt <= presc_cnt + 1'b1;
				end
			end else begin
				sclk <= con_i.cpol;	// Idle level tracks polarity
			end
			if (done && !con_i.enable)
				done <= 1'b0;	// Software acknowledged
		end
	end

	// Shift registers
	always_ff @(posedge clk) begin
		if (start) begin
			cfg_q	<= con_i;
			tx_sh	<= con_i.order ? din_rev : din_i;
		end else if (tick) begin
			if (sample)
				rx_sh <= rx_next;
			else if (edge_cnt != '0)
				tx_sh <= {tx_sh[W-2:0], 1'b0};	// Next bit on the shift edge
		end
	end

	always_comb begin
		stat_o		= '0;
		stat_o.busy	= busy;
		stat_o.done	= done;
	end

	assign sck_o = sclk;
	assign mosi_o = tx_sh[W-1];
	assign ss_n_o = busy ? ~(4'b0001 << cfg_q.select) : 4'hf;	// Only selected line low

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module uart_tx (
	input  logic						clk,
	input  logic						nrst,
	input  periph_pkg::uart_con_t		con_i,
	input  logic [`PERIPH_FRAME_W-1:0]	din_i,
	output logic						tx_busy_o,
	output logic						tx_done_o,
	output logic						uart_tx_o
);

	localparam int FRAME_LEN = `PERIPH_FRAME_W + 3;	// Start, data, parity, stop
	localparam int IDX_W = $clog2(FRAME_LEN);

	logic [23:0]			div_q;
	logic [23:0]			baud_cnt;
	logic [FRAME_LEN-2:0]	shift_q;	// Bits after the start bit
	logic [IDX_W-1:0]		bit_idx;	// Bit now on the line
	logic [IDX_W-1:0]		last_idx;
	logic					start;
	logic					baud_tick;

	assign start = con_i.tx_go & ~tx_busy_o & ~tx_done_o;
	assign baud_tick = tx_busy_o & (baud_cnt == div_q);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			tx_busy_o	<= 1'b0;
			tx_done_o	<= 1'b0;
			uart_tx_o	<= 1'b1;	// Line idles high
			baud_cnt	<= '0;
			bit_idx		<= '0;
		end else begin
			if (start) begin
				tx_busy_o	<= 1'b1;
				uart_tx_o	<= 1'b0;	// Start bit
				baud_cnt	<= '0;
				bit_idx		<= '0;
			end else if (baud_tick) begin
				baud_cnt <= '0;
				if (bit_idx == last_idx) begin
					tx_busy_o	<= 1'b0;
					tx_done_o	<= 1'b1;
					uart_tx_o	<= 1'b1;
				end else begin
					uart_tx_o	<= shift_q[0];
					bit_idx		<= bit_idx + 1'b1;
				end
			end else if (tx_busy_o) begin
				baud_cnt <= baud_cnt + 1'b1;
			end
			if (tx_done_o && !con_i.tx_go)
				tx_done_o <= 1'b0;
		end
	end

	// Frame image, LSB first
	always_ff @(posedge clk) begin
		if (start) begin
			div_q		<= con_i.baud_div;
			// Without parity the parity slot is a second stop level never sent
			shift_q		<= {1'b1, con_i.parity_en ? ^din_i : 1'b1, din_i};
			last_idx	<= con_i.parity_en ? IDX_W'(FRAME_LEN - 1) : IDX_W'(FRAME_LEN - 2);
		end else if (baud_tick) begin
			shift_q <= {1'b1, shift_q[FRAME_LEN-2:1]};
		end
	end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module uart_rx (
	input  logic						clk,
	input  logic						nrst,
	input  logic [23:0]					baud_div_i,
	input  logic						parity_en_i,
	input  logic						uart_rx_i,
	output logic [`PERIPH_FRAME_W-1:0]	dout_o,
	output logic [3:0]					rx_count_o,
	output logic						parity_err_o
);

	localparam int W = `PERIPH_FRAME_W;
	localparam int IDX_W = $clog2(W + 3);

	logic [1:0]			sync_q;		// Two-flop synchronizer
	logic				rx_s;
	logic				rx_prev;
	logic				active;
	logic [23:0]		baud_cnt;
	logic [23:0]		bit_len;
	logic [IDX_W-1:0]	bit_idx;	// 0 is start bit
	logic [W-1:0]		shift_q;
	logic				par_q;
	logic				mid;
	logic				is_data;
	logic				is_par;
	logic				is_stop;

	assign rx_s = sync_q[1];
	// Half a bit to reach the start bit middle, full bits after that
	assign bit_len = (bit_idx == '0) ? {1'b0, baud_div_i[23:1]} : baud_div_i;
	assign mid = active & (baud_cnt == bit_len);
	assign is_data = (bit_idx != '0) && (bit_idx <= IDX_W'(W));
	assign is_par = parity_en_i && (bit_idx == IDX_W'(W + 1));
	assign is_stop = (bit_idx > IDX_W'(W)) && !is_par;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			sync_q			<= 2'b11;
			rx_prev			<= 1'b1;
			active			<= 1'b0;
			baud_cnt		<= '0;
			bit_idx			<= '0;
			dout_o			<= '0;
			rx_count_o		<= '0;
			parity_err_o	<= 1'b0;
		end else begin
			sync_q	<= {sync_q[0], uart_rx_i};
			rx_prev	<= rx_s;
			if (!active) begin
				if (rx_prev && !rx_s) begin	// Falling edge of start bit
					active		<= 1'b1;
					baud_cnt	<= '0;
					bit_idx		<= '0;
				end
			end else if (mid) begin
				baud_cnt	<= '0;
				bit_idx		<= bit_idx + 1'b1;
				if (bit_idx == '0 && rx_s) begin
					active <= 1'b0;	// Glitch, not a real start
				end else if (is_stop) begin
					active			<= 1'b0;
					dout_o			<= shift_q;
					rx_count_o		<= rx_count_o + 1'b1;	// Wraps
					parity_err_o	<= parity_en_i & (^shift_q ^ par_q);	// Even parity
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (mid && is_data)
			shift_q <= {rx_s, shift_q[W-1:1]};
		if (mid && is_par)
			par_q <= rx_s;
	end

endmodule

/* logic/periph_top.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_top (
	input  logic					clk,
	input  logic					nrst,
	input  logic [31:0]				mem_rdata_i,
	output periph_pkg::mem_req_t	mem_req_o,
	output logic					sck_o,
	output logic					mosi_o,
	input  logic					miso_i,
	output logic [3:0]				ss_n_o,
	output logic					uart_tx_o,
	input  logic					uart_rx_i,
	output logic					irq_o
);

	localparam int W = `PERIPH_FRAME_W;

	periph_pkg::spi_con_t	spi_con;
	periph_pkg::spi_stat_t	spi_stat;
	logic [W-1:0]			spi_din;
	logic [W-1:0]			spi_dout;
	periph_pkg::uart_con_t	uart_con;
	periph_pkg::uart_stat_t	uart_stat;
	logic [W-1:0]			uart_din;
	logic [W-1:0]			uart_dout;
	logic					tx_busy;
	logic					tx_done;
	logic					rx_parity_err;
	logic [3:0]				rx_count;

	mailbox_poller u_poller (
		.clk, .nrst, .mem_rdata_i, .mem_req_o,
		.spi_con_o(spi_con), .spi_din_o(spi_din),
		.spi_stat_i(spi_stat), .spi_dout_i(spi_dout),
		.uart_con_o(uart_con), .uart_din_o(uart_din),
		.uart_stat_i(uart_stat), .uart_dout_i(uart_dout),
		.irq_o
	);

	spi_master u_spi (
		.clk, .nrst, .con_i(spi_con), .din_i(spi_din),
		.stat_o(spi_stat), .dout_o(spi_dout),
		.sck_o, .mosi_o, .miso_i, .ss_n_o
	);

	uart_tx u_uart_tx (
		.clk, .nrst, .con_i(uart_con), .din_i(uart_din),
		.tx_busy_o(tx_busy), .tx_done_o(tx_done), .uart_tx_o
	);

	// Receiver shares divisor and parity with the transmitter
	uart_rx u_uart_rx (
		.clk, .nrst, .baud_div_i(uart_con.baud_div), .parity_en_i(uart_con.parity_en),
		.uart_rx_i, .dout_o(uart_dout), .rx_count_o(rx_count), .parity_err_o(rx_parity_err)
	);

	always_comb begin
		uart_stat				= '0;
		uart_stat.tx_busy		= tx_busy;
		uart_stat.tx_done		= tx_done;
		uart_stat.rx_parity_err	= rx_parity_err;
		uart_stat.rx_count		= rx_count;
	end

endmodule

/* dv/periph_checker.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_checker (
	input logic			clk,
	input logic			nrst,
	input logic [3:0]	ss_n_i,
	input logic [3:0]	wstrb_i,
	input logic			irq_i,
	input logic			spi_done_i,
	input logic			tx_done_i,
	input logic [3:0]	rx_count_i
);

	// Detection delay of up to a sweep plus one armed sweep
	localparam int RX_WINDOW = 2 * `PERIPH_SWEEP_LEN + 2;

	logic [5:0]	since_rx;	// Cycles since rx_count last moved, saturating
	logic [3:0]	rx_last;
	int			fail_cnt = 0;	// Read by the testbench at the end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			rx_last		<= '0;
			since_rx	<= '1;
		end else begin
			rx_last <= rx_count_i;
			if (rx_count_i != rx_last)
				since_rx <= '0;
			else if (since_rx != '1)
				since_rx <= since_rx + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!nrst) $onehot0(~ss_n_i))
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("More than one chip select low");
		end

	assert property (@(posedge clk) disable iff (!nrst) (wstrb_i == 4'h0 || wstrb_i == 4'hf))
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("Partial write strobe");
		end

	// irq is registered, so its causes are one cycle older
	assert property (@(posedge clk) disable iff (!nrst)
		irq_i |-> ($past(spi_done_i) || $past(tx_done_i) || $past(since_rx) < 6'(RX_WINDOW)))
		else begin
			fail_cnt <= fail_cnt + 1;
			$error("irq high without a done flag or recent receive");
		end

endmodule

bind periph_top periph_checker u_checker (
	.clk, .nrst,
	.ss_n_i(ss_n_o), .wstrb_i(mem_req_o.wstrb), .irq_i(irq_o),
	.spi_done_i(spi_stat.done), .tx_done_i(tx_done), .rx_count_i(rx_count)
);

/* dv/periph_tb.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_tb;

	localparam int SWEEP = `PERIPH_SWEEP_LEN;
	localparam int TIMEOUT = 20 * SWEEP;	// Cycles allowed per polling loop
	localparam int MEM_WORDS = 2048;
	localparam int DONE_BIT = 1;			// Done sits in bit 1 of both status words

	logic					clk;
	logic					nrst;
	logic [31:0]			mem_rdata = '0;
	periph_pkg::mem_req_t	mem_req;
	logic					sck;
	logic					mosi;
	logic [3:0]				ss_n;
	logic					uart_tx;
	logic					irq;

	logic [31:0]				mem [0:MEM_WORDS-1];	// Shared data memory
	logic						cpu_we;
	logic [`PERIPH_ADDR_W-1:0]	cpu_addr;
	logic [31:0]				cpu_wdata;
	integer						seed = 32'hd58eb794;
	logic [3:0]					rx_model;	// Expected receive count
	logic [7:0]					sent_q [$];	// Bytes still to arrive at UART_DOUT

	// Both links looped back on themselves
	periph_top dut (
		.clk, .nrst,
		.mem_rdata_i(mem_rdata), .mem_req_o(mem_req),
		.sck_o(sck), .mosi_o(mosi), .miso_i(mosi), .ss_n_o(ss_n),
		.uart_tx_o(uart_tx), .uart_rx_i(uart_tx),
		.irq_o(irq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Memory answers reads one cycle late, writes land on the edge
	always @(posedge clk) begin
		mem_rdata <= mem[mem_req.addr];
		if (!nrst) begin
			for (int a = 0; a < MEM_WORDS; a++)
				mem[a] <= 32'h0;	// Mailboxes start idle
		end else begin
			if (mem_req.wstrb == 4'hf)
				mem[mem_req.addr] <= mem_req.wdata;
			if (cpu_we)
				mem[cpu_addr] <= cpu_wdata;	// CPU only touches the input mailbox
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_spi_stat(input periph_pkg::spi_stat_t exp);
		periph_pkg::spi_stat_t got;
		got = mem[`MB_SPI_STAT];
		if (got !== exp)
			abort_run($sformatf("ERROR at %0d ns: SPI_STAT expected %h, got %h",
				$time, exp, got));
	endtask

	task automatic check_uart_stat(input periph_pkg::uart_stat_t exp);
		periph_pkg::uart_stat_t got;
		got = mem[`MB_UART_STAT];
		if (got !== exp)
			abort_run($sformatf("ERROR at %0d ns: UART_STAT expected %h (count %0d), got %h",
				$time, exp, exp.rx_count, got));
	endtask

	// Upper bytes of a data word must be zero
	task automatic check_byte(input string what, input logic [`PERIPH_ADDR_W-1:0] addr,
			input logic [7:0] exp);
		if (mem[addr] !== {24'h0, exp})
			abort_run($sformatf("ERROR at %0d ns: %s expected %h, got %h",
				$time, what, exp, mem[addr]));
	endtask

	task automatic check_mask(input string what, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0d ns: %s expected %b, got %b",
				$time, what, exp, got));
	endtask

	task automatic check_pin(input string what, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0d ns: %s expected %b, got %b",
				$time, what, exp, got));
	endtask

	task automatic cpu_write(input logic [`PERIPH_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_we = 1'b1;
		@(negedge clk);
		cpu_we = 1'b0;
	endtask

	// Mailbox latency, two sweeps at most
	task automatic settle(input int sweeps);
		repeat (sweeps * SWEEP) @(negedge clk);
	endtask

	// Polls a status word until done reaches the level, noting chip selects seen low
	task automatic wait_done(input logic [`PERIPH_ADDR_W-1:0] addr, input logic level,
			input string what, output logic [3:0] ss_seen);
		int n;
		n = 0;
		ss_seen = 4'h0;
		while (mem[addr][DONE_BIT] !== level) begin
			@(negedge clk);
			ss_seen |= ~ss_n;
			n++;
			if (n > TIMEOUT)
				abort_run($sformatf("Timeout: %s did not go to %0b within %0d cycles",
					what, level, TIMEOUT));
		end
	endtask

	task automatic spi_transfer();
		periph_pkg::spi_con_t	con;
		periph_pkg::spi_stat_t	exp;
		logic [7:0]				data;
		logic [3:0]				ss_seen;
		data = 8'($random(seed));
		con = '0;
		con.prescale = 24'($random(seed) & 3);
		con.cpol = 1'($random(seed));
		con.cpha = 1'($random(seed));
		con.order = 1'($random(seed));
		con.select = 2'($random(seed));
		cpu_write(`MB_SPI_DIN, {24'h0, data});
		settle(2);	// Data latched before enable arrives
		con.enable = 1'b1;
		cpu_write(`MB_SPI_CON, con);
		wait_done(`MB_SPI_STAT, 1'b1, "SPI done", ss_seen);
		settle(2);	// Done has to hold across sweeps
		exp = '0;
		exp.done = 1'b1;
		check_spi_stat(exp);
		check_byte("SPI_DOUT", `MB_SPI_DOUT, data);
		check_mask("chip selects driven low", ss_seen, 4'b0001 << con.select);
		check_pin("SCK idle level", sck, con.cpol);
		check_pin("irq with SPI done", irq, 1'b1);
		con.enable = 1'b0;	// Acknowledge
		cpu_write(`MB_SPI_CON, con);
		wait_done(`MB_SPI_STAT, 1'b0, "SPI done clear", ss_seen);
		exp.done = 1'b0;
		check_spi_stat(exp);
		check_pin("irq after SPI acknowledge", irq, 1'b0);
	endtask

	task automatic uart_transfer();
		periph_pkg::uart_con_t	con;
		periph_pkg::uart_stat_t	exp;
		logic [7:0]				data;
		logic [3:0]				ss_seen;
		data = 8'($random(seed));
		con = '0;
		con.baud_div = 24'(3 + ({$random(seed)} % 7));
		con.parity_en = 1'($random(seed));
		sent_q.push_back(data);
		rx_model = rx_model + 4'd1;	// Wraps like the DUT counter
		cpu_write(`MB_UART_DIN, {24'h0, data});
		settle(2);
		con.tx_go = 1'b1;
		cpu_write(`MB_UART_CON, con);
		wait_done(`MB_UART_STAT, 1'b1, "UART tx_done", ss_seen);
		settle(2);	// Receiver finishes near the end of the stop bit
		exp = '0;
		exp.tx_done = 1'b1;
		exp.rx_count = rx_model;
		check_uart_stat(exp);
		check_byte("UART_DOUT", `MB_UART_DOUT, sent_q.pop_front());
		check_mask("chip selects during UART", ss_seen, 4'h0);
		check_pin("irq with UART tx_done", irq, 1'b1);
		con.tx_go = 1'b0;
		cpu_write(`MB_UART_CON, con);
		wait_done(`MB_UART_STAT, 1'b0, "UART tx_done clear", ss_seen);
		exp.tx_done = 1'b0;
		check_uart_stat(exp);
		check_pin("irq after UART acknowledge", irq, 1'b0);
	endtask

	initial begin
		nrst = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		rx_model = '0;
		repeat (16) @(negedge clk);
		check_mask("ss_n in reset", ss_n, 4'hf);
		check_pin("UART line in reset", uart_tx, 1'b1);
		check_pin("irq in reset", irq, 1'b0);
		check_pin("SCK in reset", sck, 1'b0);
		nrst = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_mask("write strobe after reset", mem_req.wstrb, 4'h0);
		end
		repeat (6) spi_transfer();	// Random modes, prescale and select
		repeat (6) uart_transfer();	// Random divisors and parity
		repeat (16) begin	// Interleaved burst
			if (1'($random(seed)))
				spi_transfer();
			else
				uart_transfer();
		end
		if (dut.u_checker.fail_cnt == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			abort_run("The bound assertion checker reported a violation");
		end
	end

endmodule

/* sources.f */
+incdir+logic
logic/periph_pkg.sv
logic/mailbox_poller.sv
logic/spi_master.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/periph_top.sv
dv/periph_checker.sv
dv/periph_tb.sv

/* Makefile */
SIM      ?= verilator
SIMFLAGS ?= --binary --assert -j 0
TOP      ?= periph_tb
BUILD    ?= obj_dir
LOG      ?= sim.log
FILELIST ?= sources.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/periph_params.svh
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Verification failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ] || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended abnormally, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
